//--- rtl/int_pkg.sv
`default_nettype none

package int_pkg;

  // datapath widths
  localparam int data_w    = 32;
  localparam int shamt_w   = 5;
  localparam int op_w      = 5;
  localparam int rs_addr_w = 3;
  localparam int exc_w     = 8;

  // overflow-checked flag inside the exception word
  localparam int exc_pos_ov = 2;

  // operation codes, anything unlisted acts as nop
  localparam logic [op_w-1:0] op_nop  = 5'd0;
  localparam logic [op_w-1:0] op_add  = 5'd1;
  localparam logic [op_w-1:0] op_addu = 5'd2;
  localparam logic [op_w-1:0] op_sub  = 5'd3;
  localparam logic [op_w-1:0] op_subu = 5'd4;
  localparam logic [op_w-1:0] op_slt  = 5'd5;
  localparam logic [op_w-1:0] op_sltu = 5'd6;
  localparam logic [op_w-1:0] op_and  = 5'd7;
  localparam logic [op_w-1:0] op_nor  = 5'd8;
  localparam logic [op_w-1:0] op_or   = 5'd9;
  localparam logic [op_w-1:0] op_xor  = 5'd10;
  localparam logic [op_w-1:0] op_sll  = 5'd11;
  localparam logic [op_w-1:0] op_sra  = 5'd12;
  localparam logic [op_w-1:0] op_srl  = 5'd13;
  localparam logic [op_w-1:0] op_clz  = 5'd14;
  localparam logic [op_w-1:0] op_clo  = 5'd15;
  localparam logic [op_w-1:0] op_movz = 5'd16;
  localparam logic [op_w-1:0] op_movn = 5'd17;

  // configuration register map
  localparam int cfg_addr_w = 1;

  localparam logic [cfg_addr_w-1:0] cfg_addr_ctrl  = 1'b0;
  localparam logic [cfg_addr_w-1:0] cfg_addr_ovcnt = 1'b1;

  // overflow counter, saturating
  localparam int ovcnt_w = 16;

endpackage

`default_nettype wire

//--- rtl/bit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module bit_counter (
  input  wire logic [int_pkg::op_w-1:0]   op,
  input  wire logic [int_pkg::data_w-1:0] opr,
  output logic      [int_pkg::data_w-1:0] count
);

  logic [int_pkg::data_w-1:0] word;
  logic [int_pkg::data_w-1:0] lead;

  // clo is clz of the inverted word
  assign word = (op == int_pkg::op_clo) ? ~opr : opr;

  // highest set bit wins, so scan upward and keep the last hit
  always_comb begin
    lead = int_pkg::data_w'(int_pkg::data_w);
    for (int i = 0; i < int_pkg::data_w; i++) begin
      if (word[i]) begin
        lead = int_pkg::data_w'(int_pkg::data_w - 1 - i);
      end
    end
  end

  always_comb begin
    if (op == int_pkg::op_clz || op == int_pkg::op_clo) begin
      count = lead;
    end else begin
      count = '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/int_unit.sv
`timescale 1ns/1ns
`default_nettype none

module int_unit (
  input  wire logic                          clk,
  input  wire logic                          arst_n,
  // issue from the integer reservation station
  input  wire logic                          issue_valid,
  input  wire logic [int_pkg::rs_addr_w-1:0] issue_rs_addr,
  input  wire logic [int_pkg::op_w-1:0]      issue_op,
  input  wire logic [int_pkg::exc_w-1:0]     issue_exc,
  input  wire logic [int_pkg::data_w-1:0]    issue_opr1,
  input  wire logic [int_pkg::data_w-1:0]    issue_opr2,
  input  wire logic                          ov_trap_en,
  // toward integer writeback
  output logic                               wb_valid,
  output logic                               wb_write,
  output logic      [int_pkg::rs_addr_w-1:0] wb_rs_addr,
  output logic      [int_pkg::exc_w-1:0]     wb_exc,
  output logic      [int_pkg::data_w-1:0]    wb_result,
  output logic                               ov_event
);

  localparam int msb = int_pkg::data_w - 1;

  logic                       negate;
  logic [int_pkg::data_w-1:0] opr2_mux;
  logic [int_pkg::data_w-1:0] sum;
  logic                       overflow_sum;
  logic                       lt_signed;
  logic                       lt_unsigned;
  logic [int_pkg::shamt_w-1:0] shamt;
  logic [int_pkg::data_w-1:0] count;
  logic [int_pkg::data_w-1:0] result;
  logic                       write_flag;
  logic [int_pkg::exc_w-1:0]  exc_gated;

  // shared adder, subtraction as a + ~b + 1
  assign negate = (issue_op == int_pkg::op_sub) || (issue_op == int_pkg::op_subu) ||
                  (issue_op == int_pkg::op_slt);
  assign opr2_mux = negate ? ~issue_opr2 : issue_opr2;
  assign sum = issue_opr1 + opr2_mux + int_pkg::data_w'(negate);

  // same input signs but a different result sign
  assign overflow_sum = (issue_opr1[msb] == opr2_mux[msb]) && (sum[msb] != issue_opr1[msb]);

  // negative vs positive, or equal signs and a negative difference
  assign lt_signed = (issue_opr1[msb] && !issue_opr2[msb]) ||
                     ((issue_opr1[msb] == issue_opr2[msb]) && sum[msb]);
  assign lt_unsigned = issue_opr1 < issue_opr2;

  assign shamt = issue_opr1[int_pkg::shamt_w-1:0];

  bit_counter bit_counter_i (
    .op    (issue_op),
    .opr   (issue_opr1),
    .count (count)
  );

  always_comb begin
    case (issue_op)
      int_pkg::op_add, int_pkg::op_addu,
      int_pkg::op_sub, int_pkg::op_subu: result = sum;
      int_pkg::op_slt:  result = int_pkg::data_w'(lt_signed);
      int_pkg::op_sltu: result = int_pkg::data_w'(lt_unsigned);
      int_pkg::op_and:  result = issue_opr1 & issue_opr2;
      int_pkg::op_nor:  result = ~(issue_opr1 | issue_opr2);
      int_pkg::op_or:   result = issue_opr1 | issue_opr2;
      int_pkg::op_xor:  result = issue_opr1 ^ issue_opr2;
      int_pkg::op_sll:  result = issue_opr2 << shamt;
      int_pkg::op_sra:  result = $signed(issue_opr2) >>> shamt;
      int_pkg::op_srl:  result = issue_opr2 >> shamt;
      int_pkg::op_clz, int_pkg::op_clo: result = count;
      int_pkg::op_movz, int_pkg::op_movn: result = issue_opr1;
      default:          result = '0;
    endcase
  end

  // register write rule, conditional for the moves
  always_comb begin
    case (issue_op)
      int_pkg::op_movz: write_flag = ~|issue_opr2;
      int_pkg::op_movn: write_flag = |issue_opr2;
      default: write_flag = (issue_op >= int_pkg::op_add) && (issue_op <= int_pkg::op_clo);
    endcase
  end

  // only the overflow flag is touched
  always_comb begin
    exc_gated = issue_exc;
    exc_gated[int_pkg::exc_pos_ov] = issue_exc[int_pkg::exc_pos_ov] && overflow_sum &&
                                     ov_trap_en;
  end

  // output register toward writeback
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid   <= 1'b0;
      wb_write   <= 1'b0;
      wb_rs_addr <= '0;
      wb_exc     <= '0;
      wb_result  <= '0;
    end else begin
      wb_valid <= issue_valid;
      wb_write <= issue_valid && write_flag;
      if (issue_valid) begin
        wb_rs_addr <= issue_rs_addr;
        wb_exc     <= exc_gated;
        wb_result  <= result;
      end
    end
  end

  assign ov_event = wb_valid && wb_exc[int_pkg::exc_pos_ov];

endmodule

`default_nettype wire

//--- rtl/int_status_regs.sv
`timescale 1ns/1ns
`default_nettype none

module int_status_regs (
  input  wire logic                           clk,
  input  wire logic                           arst_n,
  input  wire logic                           cfg_we,
  input  wire logic [int_pkg::cfg_addr_w-1:0] cfg_addr,
  input  wire logic [int_pkg::data_w-1:0]     cfg_wdata,
  input  wire logic                           ov_event,
  output logic      [int_pkg::data_w-1:0]     cfg_rdata,
  output logic                                ov_trap_en
);

  logic [int_pkg::ovcnt_w-1:0] ovcnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ov_trap_en <= 1'b1;
    end else if (cfg_we && cfg_addr == int_pkg::cfg_addr_ctrl) begin
      ov_trap_en <= cfg_wdata[0];
    end
  end

  // a clear beats a same-cycle increment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ovcnt <= '0;
    end else if (cfg_we && cfg_addr == int_pkg::cfg_addr_ovcnt) begin
      ovcnt <= '0;
    end else if (ov_event && ovcnt != '1) begin
      ovcnt <= ovcnt + 1'b1;
    end
  end

  always_comb begin
    if (cfg_addr == int_pkg::cfg_addr_ctrl) begin
      cfg_rdata = int_pkg::data_w'(ov_trap_en);
    end else begin
      cfg_rdata = int_pkg::data_w'(ovcnt);
    end
  end

endmodule

`default_nettype wire

//--- rtl/int_exec.sv
`timescale 1ns/1ns
`default_nettype none

module int_exec (
  input  wire logic                           clk,
  input  wire logic                           arst_n,
  // issue
  input  wire logic                           issue_valid,
  input  wire logic [int_pkg::rs_addr_w-1:0]  issue_rs_addr,
  input  wire logic [int_pkg::op_w-1:0]       issue_op,
  input  wire logic [int_pkg::exc_w-1:0]      issue_exc,
  input  wire logic [int_pkg::data_w-1:0]     issue_opr1,
  input  wire logic [int_pkg::data_w-1:0]     issue_opr2,
  // writeback
  output logic                                wb_valid,
  output logic                                wb_write,
  output logic      [int_pkg::rs_addr_w-1:0]  wb_rs_addr,
  output logic      [int_pkg::exc_w-1:0]      wb_exc,
  output logic      [int_pkg::data_w-1:0]     wb_result,
  // configuration port
  input  wire logic                           cfg_we,
  input  wire logic [int_pkg::cfg_addr_w-1:0] cfg_addr,
  input  wire logic [int_pkg::data_w-1:0]     cfg_wdata,
  output logic      [int_pkg::data_w-1:0]     cfg_rdata
);

  logic ov_trap_en;
  logic ov_event;

  int_unit int_unit_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue_valid   (issue_valid),
    .issue_rs_addr (issue_rs_addr),
    .issue_op      (issue_op),
    .issue_exc     (issue_exc),
    .issue_opr1    (issue_opr1),
    .issue_opr2    (issue_opr2),
    .ov_trap_en    (ov_trap_en),
    .wb_valid      (wb_valid),
    .wb_write      (wb_write),
    .wb_rs_addr    (wb_rs_addr),
    .wb_exc        (wb_exc),
    .wb_result     (wb_result),
    .ov_event      (ov_event)
  );

  int_status_regs int_status_regs_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .ov_event   (ov_event),
    .cfg_rdata  (cfg_rdata),
    .ov_trap_en (ov_trap_en)
  );

endmodule

`default_nettype wire

//--- tb/int_exec_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module int_exec_asserts (
  input wire logic                      clk,
  input wire logic                      arst_n,
  input wire logic                      issue_valid,
  input wire logic                      wb_valid,
  input wire logic                      wb_write,
  input wire logic [int_pkg::exc_w-1:0] wb_exc,
  input wire logic                      ov_event
);

  // number of property failures so far
  int fail_count = 0;

  // fixed one-cycle latency
  issue_to_wb: assert property (@(posedge clk) disable iff (!arst_n)
    issue_valid |=> wb_valid)
    else begin
      $error("wb_valid did not follow issue_valid by one cycle");
      fail_count++;
    end

  write_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
    wb_write |-> wb_valid)
    else begin
      $error("wb_write high without wb_valid");
      fail_count++;
    end

  ov_event_source: assert property (@(posedge clk) disable iff (!arst_n)
    ov_event |-> wb_valid && wb_exc[int_pkg::exc_pos_ov])
    else begin
      $error("ov_event without a valid overflow writeback");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> !wb_valid && !wb_write && !ov_event)
    else begin
      $error("strobe high while reset is asserted");
      fail_count++;
    end

endmodule

bind int_exec int_exec_asserts asserts_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .issue_valid (issue_valid),
  .wb_valid    (wb_valid),
  .wb_write    (wb_write),
  .wb_exc      (wb_exc),
  .ov_event    (ov_event)
);

`default_nettype wire

//--- tb/int_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module int_exec_tb;

  localparam int len_ops     = 401;
  localparam int len_moves   = 49;
  localparam int len_ovf     = 131;
  localparam int len_cnt     = 12;
  localparam int len_bits    = 85;
  localparam int cycle_limit = 17 + len_ops + len_moves + len_ovf + len_cnt + len_bits + 200;

  logic        clk;
  logic        arst_n;
  logic        issue_valid;
  logic [2:0]  issue_rs_addr;
  logic [4:0]  issue_op;
  logic [7:0]  issue_exc;
  logic [31:0] issue_opr1;
  logic [31:0] issue_opr2;
  logic        wb_valid;
  logic        wb_write;
  logic [2:0]  wb_rs_addr;
  logic [7:0]  wb_exc;
  logic [31:0] wb_result;
  logic        cfg_we;
  logic [0:0]  cfg_addr;
  logic [31:0] cfg_wdata;
  logic [31:0] cfg_rdata;

  // model state lags the issue by one cycle
  logic        exp_valid;
  logic        exp_write;
  logic [2:0]  exp_rs;
  logic [7:0]  exp_exc;
  logic [31:0] exp_result;
  logic        model_trap_en;
  logic [15:0] model_ovcnt;
  logic [0:0]  last_cfg_addr;
  logic [31:0] rng;
  int          checks;
  int          errors;
  int          cycles;

  int_exec dut_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not end within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // corner values show up often
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = xorshift();
    case (r[2:0])
      3'd0: return 32'h0000_0000;
      3'd1: return 32'hffff_ffff;
      3'd2: return 32'h8000_0000;
      3'd3: return 32'h7fff_ffff;
      3'd4: return {27'b0, r[8:4]};
      default: return xorshift();
    endcase
  endfunction

  function automatic logic [31:0] lead_count(input logic [31:0] w, input logic ones);
    int n;
    n = 0;
    for (int i = 31; i >= 0; i--) begin
      if (w[i] != ones) break;
      n++;
    end
    return 32'(n);
  endfunction

  function automatic logic [31:0] model_result(input logic [4:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
    case (op)
      int_pkg::op_add, int_pkg::op_addu: return a + b;
      int_pkg::op_sub, int_pkg::op_subu: return a - b;
      int_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      int_pkg::op_sltu: return (a < b) ? 32'd1 : 32'd0;
      int_pkg::op_and:  return a & b;
      int_pkg::op_nor:  return ~(a | b);
      int_pkg::op_or:   return a | b;
      int_pkg::op_xor:  return a ^ b;
      int_pkg::op_sll:  return b << a[4:0];
      int_pkg::op_sra:  return $signed(b) >>> a[4:0];
      int_pkg::op_srl:  return b >> a[4:0];
      int_pkg::op_clz:  return lead_count(a, 1'b0);
      int_pkg::op_clo:  return lead_count(a, 1'b1);
      int_pkg::op_movz, int_pkg::op_movn: return a;
      default: return 32'd0;
    endcase
  endfunction

  // nop and unknown codes never write
  function automatic logic model_write(input logic [4:0] op, input logic [31:0] b);
    case (op)
      int_pkg::op_movz: return b == 32'd0;
      int_pkg::op_movn: return b != 32'd0;
      int_pkg::op_add, int_pkg::op_addu, int_pkg::op_sub, int_pkg::op_subu,
      int_pkg::op_slt, int_pkg::op_sltu, int_pkg::op_and, int_pkg::op_nor,
      int_pkg::op_or, int_pkg::op_xor, int_pkg::op_sll, int_pkg::op_sra,
      int_pkg::op_srl, int_pkg::op_clz, int_pkg::op_clo: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // overflow when the 64-bit result no longer fits 32 signed bits
  function automatic logic [7:0] model_exc(input logic [4:0] op, input logic [7:0] exc,
                                           input logic [31:0] a, input logic [31:0] b,
                                           input logic trap_en);
    longint s;
    logic [7:0] e;
    if (op == int_pkg::op_sub || op == int_pkg::op_subu || op == int_pkg::op_slt) begin
      s = longint'($signed(a)) - longint'($signed(b));
    end else begin
      s = longint'($signed(a)) + longint'($signed(b));
    end
    e = exc;
    e[int_pkg::exc_pos_ov] = exc[int_pkg::exc_pos_ov] && (s[63:31] != {33{s[31]}}) && trap_en;
    return e;
  endfunction

  task automatic check(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("ERROR %0t: %s", $time, what);
    end
  endtask

  task automatic check_outputs();
    logic [31:0] rd;
    rd = (last_cfg_addr == int_pkg::cfg_addr_ctrl) ? {31'b0, model_trap_en} : {16'b0, model_ovcnt};
    check(wb_valid === exp_valid, $sformatf("wb_valid %b, expected %b", wb_valid, exp_valid));
    check(wb_write === exp_write, $sformatf("wb_write %b, expected %b", wb_write, exp_write));
    if (exp_valid) begin
      check(wb_rs_addr === exp_rs, $sformatf("wb_rs_addr %0d, expected %0d", wb_rs_addr, exp_rs));
      check(wb_exc === exp_exc, $sformatf("wb_exc %h, expected %h", wb_exc, exp_exc));
      check(wb_result === exp_result,
            $sformatf("wb_result %h, expected %h", wb_result, exp_result));
    end
    check(cfg_rdata === rd, $sformatf("cfg_rdata %h, expected %h", cfg_rdata, rd));
  endtask

  // last results are checked before the model moves on and new inputs go out
  task automatic step(input logic valid, input logic [2:0] rs, input logic [4:0] op,
                      input logic [7:0] exc, input logic [31:0] a, input logic [31:0] b,
                      input logic we, input logic [0:0] addr, input logic [31:0] wdata);
    logic ov_now;
    @(negedge clk);
    check_outputs();
    ov_now = exp_valid && exp_exc[int_pkg::exc_pos_ov];
    exp_valid = valid;
    exp_write = valid && model_write(op, b);
    if (valid) begin
      exp_rs = rs;
      exp_exc = model_exc(op, exc, a, b, model_trap_en);
      exp_result = model_result(op, a, b);
    end
    if (we && addr == int_pkg::cfg_addr_ctrl) model_trap_en = wdata[0];
    // clear beats increment
    if (we && addr == int_pkg::cfg_addr_ovcnt) begin
      model_ovcnt = 16'd0;
    end else if (ov_now && model_ovcnt != 16'hffff) begin
      model_ovcnt = model_ovcnt + 16'd1;
    end
    last_cfg_addr = addr;
    issue_valid = valid;
    issue_rs_addr = rs;
    issue_op = op;
    issue_exc = exc;
    issue_opr1 = a;
    issue_opr2 = b;
    cfg_we = we;
    cfg_addr = addr;
    cfg_wdata = wdata;
  endtask

  task automatic idle();
    step(1'b0, 3'd0, int_pkg::op_nop, 8'd0, 32'd0, 32'd0, 1'b0, int_pkg::cfg_addr_ovcnt, 32'd0);
  endtask

  task automatic cfg_write(input logic [0:0] addr, input logic [31:0] wdata);
    step(1'b0, 3'd0, int_pkg::op_nop, 8'd0, 32'd0, 32'd0, 1'b1, addr, wdata);
  endtask

  // add and sub operands built to overflow about half the time
  task automatic issue_add_sub(input int n, input logic force_ov);
    logic [31:0] r;
    logic [31:0] e;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  op;
    for (int i = 0; i < n; i++) begin
      r = xorshift();
      e = xorshift();
      op = r[0] ? int_pkg::op_add : int_pkg::op_sub;
      if (r[1] || force_ov) begin
        a = (r[0] ? 32'h7000_0000 : 32'h9000_0000) | (e & 32'h00ff_ffff);
        b = 32'h4000_0000;
      end else begin
        a = xorshift() >> 2;
        b = e >> 2;
      end
      e[2] = r[2] || force_ov;
      step(1'b1, r[6:4], op, e[7:0], a, b, 1'b0, int_pkg::cfg_addr_ovcnt, 32'd0);
    end
  endtask

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    int chk0;
    int err0;
    rng = 32'd20;
    checks = 0;
    errors = 0;
    arst_n = 1'b1;
    issue_valid = 1'b0;
    issue_rs_addr = '0;
    issue_op = '0;
    issue_exc = '0;
    issue_opr1 = '0;
    issue_opr2 = '0;
    cfg_we = 1'b0;
    cfg_addr = int_pkg::cfg_addr_ovcnt;
    cfg_wdata = '0;
    exp_valid = 1'b0;
    exp_write = 1'b0;
    exp_rs = '0;
    exp_exc = '0;
    exp_result = '0;
    model_trap_en = 1'b1;
    model_ovcnt = '0;
    last_cfg_addr = int_pkg::cfg_addr_ovcnt;
    @(negedge clk);
    arst_n = 1'b0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 400; i++) begin
      r = xorshift();
      step(1'b1, r[2:0], 5'(r[15:8] % 20), r[23:16], pick_operand(), pick_operand(),
           1'b0, int_pkg::cfg_addr_ovcnt, 32'd0);
    end
    idle();
    report_test("operations", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 48; i++) begin
      r = xorshift();
      w = r[3] ? 32'd0 : pick_operand();
      step(r[0] | r[1], r[6:4], r[2] ? int_pkg::op_movz : int_pkg::op_movn, 8'd0, xorshift(),
           w, 1'b0, int_pkg::cfg_addr_ovcnt, 32'd0);
    end
    idle();
    report_test("conditional moves", chk0, err0);

    chk0 = checks;
    err0 = errors;
    issue_add_sub(64, 1'b0);
    cfg_write(int_pkg::cfg_addr_ctrl, 32'd0);
    issue_add_sub(64, 1'b0);
    cfg_write(int_pkg::cfg_addr_ctrl, 32'd1);
    idle();
    report_test("overflow gating", chk0, err0);

    // clear lands in the same cycle as the last overflow event
    chk0 = checks;
    err0 = errors;
    idle();
    issue_add_sub(4, 1'b1);
    cfg_write(int_pkg::cfg_addr_ovcnt, 32'd0);
    idle();
    idle();
    issue_add_sub(2, 1'b1);
    idle();
    idle();
    report_test("overflow counter", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 34; i++) begin
      w = (i == 32) ? 32'd0 : (i == 33) ? 32'hffff_ffff : (32'd1 << i);
      step(1'b1, 3'(i), int_pkg::op_clz, 8'd0, w, 32'd0, 1'b0, int_pkg::cfg_addr_ovcnt, 32'd0);
      step(1'b1, 3'(i), int_pkg::op_clo, 8'd0, w, 32'd0, 1'b0, int_pkg::cfg_addr_ovcnt, 32'd0);
    end
    for (int i = 0; i < 16; i++) begin
      w = xorshift() | 32'h8000_0000;
      step(1'b1, 3'(i), int_pkg::op_sra, 8'd0, i[0] ? 32'd31 : 32'd0, w, 1'b0,
           int_pkg::cfg_addr_ovcnt, 32'd0);
    end
    idle();
    report_test("leading bits and shifts", chk0, err0);

    $display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             dut_i.asserts_i.fail_count);
    if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
rtl/int_pkg.sv
rtl/bit_counter.sv
rtl/int_unit.sv
rtl/int_status_regs.sv
rtl/int_exec.sv
tb/int_exec_asserts.sv
tb/int_exec_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the int_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module int_exec_tb -o int_exec_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/int_exec_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
